// ==== common/dside_pkg.sv ====
// shared sizes, bus types and access record for the data-side checking system
// imported by the memory, tracker, shadow checker and testbench
package dside_pkg;

  // --------------------------------------------------------------------------
  // sizes
  // --------------------------------------------------------------------------

  // data memory depth in 32-bit words
  localparam int MEM_WORDS  = 256;
  // word index width, MEM_WORDS == 2**ADDR_IDX_W
  localparam int ADDR_IDX_W = 8;
  // access and mismatch counter width
  localparam int CNT_W      = 16;

  // --------------------------------------------------------------------------
  // data bus
  // --------------------------------------------------------------------------

  // request as driven by the load/store agent, held until granted
  typedef struct packed {
    logic        we;
    logic [31:0] addr;
    logic [3:0]  be;
    logic [31:0] wdata;
  } dmem_req_t;

  // response, valid one cycle after the grant
  typedef struct packed {
    logic        rvalid;
    logic [31:0] rdata;
    logic        err;
  } dmem_rsp_t;

  // misalignment flags from the LSU, valid in the request cycle
  typedef struct packed {
    logic misaligned_first;
    logic misaligned_second;
  } lsu_info_t;

  // --------------------------------------------------------------------------
  // checking side
  // --------------------------------------------------------------------------

  // one completed access
  // data is the store data for stores, the returned read data for loads
  typedef struct packed {
    logic        store;
    logic [31:0] addr;
    logic [3:0]  be;
    logic [31:0] data;
    logic        err;
    logic        misaligned_first;
    logic        misaligned_second;
  } access_rec_t;

  // whole-word write from the external writer, invisible to the model
  typedef struct packed {
    logic [ADDR_IDX_W-1:0] idx;
    logic [31:0]           data;
  } bd_wr_t;

endpackage

// ==== src/data_mem.sv ====
// word-wide data memory on the req/gnt/rvalid bus with byte enables
// grant is withheld while stalled; a backdoor port writes whole words
`timescale 1ns/1ps

module data_mem import dside_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,

  input  logic      req_i,
  input  dmem_req_t req_data_i,
  input  logic      stall_i,
  output logic      gnt_o,
  output dmem_rsp_t rsp_o,

  input  logic      bd_valid_i,
  input  bd_wr_t    bd_wr_i
);

  logic [31:0]           mem_q [MEM_WORDS];
  logic [ADDR_IDX_W-1:0] word_idx;
  logic                  out_of_range;
  logic                  xfer;
  logic                  bus_wr;
  logic                  bd_wr;

  logic                  rvalid_q;
  logic [31:0]           rdata_q;
  logic                  err_q;

  // --------------------------------------------------------------------------
  // address decode and handshake
  // --------------------------------------------------------------------------

  assign gnt_o    = req_i & ~stall_i;
  assign xfer     = req_i & gnt_o;

  // anything past the last word is an error
  assign word_idx     = req_data_i.addr[ADDR_IDX_W+1:2];
  assign out_of_range = req_data_i.addr[31:2] >= 30'(MEM_WORDS);

  assign bus_wr = xfer & req_data_i.we & ~out_of_range;
  // bus write to the same word takes priority
  assign bd_wr  = bd_valid_i & ~(bus_wr && (word_idx == bd_wr_i.idx));

  // --------------------------------------------------------------------------
  // storage
  // --------------------------------------------------------------------------

  always_ff @(posedge clk_i) begin
    if (bd_wr) begin
      mem_q[bd_wr_i.idx] <= bd_wr_i.data;
    end
    if (bus_wr) begin
      for (int b = 0; b < 4; b++) begin
        if (req_data_i.be[b]) begin
          mem_q[word_idx][8*b +: 8] <= req_data_i.wdata[8*b +: 8];
        end
      end
    end
  end

  // --------------------------------------------------------------------------
  // response
  // --------------------------------------------------------------------------

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= xfer;
    end
  end

  // stores and errors return zero read data
  always_ff @(posedge clk_i) begin
    if (xfer) begin
      err_q   <= out_of_range;
      rdata_q <= (out_of_range || req_data_i.we) ? '0 : mem_q[word_idx];
    end
  end

  assign rsp_o = '{rvalid: rvalid_q, rdata: rdata_q, err: err_q};

  // an ungranted request stays up and unchanged
  a_req_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_i && !gnt_o |=> req_i && $stable(req_data_i));

  // rvalid only in the cycle after a transfer
  a_rvalid_after_gnt: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rsp_o.rvalid |-> $past(xfer));

endmodule

// ==== cosim/dside_tracker.sv ====
// pairs each granted data request with its response
// emits one access record per completed access for the shadow checker
`timescale 1ns/1ps

module dside_tracker import dside_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,

  input  logic        req_i,
  input  logic        gnt_i,
  input  dmem_req_t   req_data_i,
  input  lsu_info_t   lsu_info_i,
  input  dmem_rsp_t   rsp_i,

  output logic        rec_valid_o,
  output access_rec_t rec_o
);

  logic        xfer;
  logic        outstanding_q;
  // request side of the record, data holds wdata until the response
  access_rec_t pend_q;

  assign xfer = req_i & gnt_i;

  // --------------------------------------------------------------------------
  // outstanding access
  // --------------------------------------------------------------------------

  // a new transfer may land in the same cycle as the previous response
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      outstanding_q <= 1'b0;
    end else if (xfer) begin
      outstanding_q <= 1'b1;
    end else if (rsp_i.rvalid) begin
      outstanding_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (xfer) begin
      pend_q.store             <= req_data_i.we;
      pend_q.addr              <= req_data_i.addr;
      pend_q.be                <= req_data_i.be;
      pend_q.data              <= req_data_i.wdata;
      pend_q.err               <= 1'b0;
      pend_q.misaligned_first  <= lsu_info_i.misaligned_first;
      pend_q.misaligned_second <= lsu_info_i.misaligned_second;
    end
  end

  // --------------------------------------------------------------------------
  // record
  // --------------------------------------------------------------------------

  assign rec_valid_o = rsp_i.rvalid;

  always_comb begin
    rec_o      = pend_q;
    rec_o.data = pend_q.store ? pend_q.data : rsp_i.rdata;
    rec_o.err  = rsp_i.err;
  end

  a_rvalid_has_access: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rsp_i.rvalid |-> outstanding_q);

endmodule

// ==== cosim/shadow_checker.sv ====
// byte-wise shadow of the stores seen by the reference model
// checks loads on known bytes and counts accesses and mismatches
`timescale 1ns/1ps

module shadow_checker import dside_pkg::*; (
  input  logic             clk_i,
  input  logic             rst_ni,

  input  logic             rec_valid_i,
  input  access_rec_t      rec_i,

  output logic             mismatch_o,
  output logic [CNT_W-1:0] access_count_o,
  output logic [CNT_W-1:0] mismatch_count_o
);

  logic [31:0]                 shadow_q [MEM_WORDS];
  logic [MEM_WORDS-1:0][3:0]   known_q;

  logic [ADDR_IDX_W-1:0]       rec_idx;
  logic                        apply_store;
  logic                        check_load;
  logic [3:0]                  check_mask;
  logic                        byte_diff;
  logic                        mismatch_d;

  logic                        mismatch_q;
  logic [CNT_W-1:0]            access_cnt_q;
  logic [CNT_W-1:0]            mismatch_cnt_q;

  // --------------------------------------------------------------------------
  // record decode
  // --------------------------------------------------------------------------

  // err records index nothing, so the low word bits are enough
  assign rec_idx     = rec_i.addr[ADDR_IDX_W+1:2];
  assign apply_store = rec_valid_i & rec_i.store & ~rec_i.err;
  assign check_load  = rec_valid_i & ~rec_i.store & ~rec_i.err;

  // only enabled bytes the model has seen written
  assign check_mask = rec_i.be & known_q[rec_idx];

  always_comb begin
    byte_diff = 1'b0;
    for (int b = 0; b < 4; b++) begin
      if (check_mask[b] && (shadow_q[rec_idx][8*b +: 8] != rec_i.data[8*b +: 8])) begin
        byte_diff = 1'b1;
      end
    end
  end

  assign mismatch_d = check_load & byte_diff;

  // --------------------------------------------------------------------------
  // shadow state
  // --------------------------------------------------------------------------

  always_ff @(posedge clk_i) begin
    if (apply_store) begin
      for (int b = 0; b < 4; b++) begin
        if (rec_i.be[b]) begin
          shadow_q[rec_idx][8*b +: 8] <= rec_i.data[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      known_q <= '0;
    end else if (apply_store) begin
      known_q[rec_idx] <= known_q[rec_idx] | rec_i.be;
    end
  end

  // --------------------------------------------------------------------------
  // mismatch pulse and counters
  // --------------------------------------------------------------------------

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mismatch_q     <= 1'b0;
      access_cnt_q   <= '0;
      mismatch_cnt_q <= '0;
    end else begin
      mismatch_q <= mismatch_d;
      // both counters stick at all ones
      if (rec_valid_i && (access_cnt_q != '1)) begin
        access_cnt_q <= access_cnt_q + 1'b1;
      end
      if (mismatch_d && (mismatch_cnt_q != '1)) begin
        mismatch_cnt_q <= mismatch_cnt_q + 1'b1;
      end
    end
  end

  assign mismatch_o       = mismatch_q;
  assign access_count_o   = access_cnt_q;
  assign mismatch_count_o = mismatch_cnt_q;

  // record comes from the tracker and the memory response
  a_rec_known: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rec_valid_i |-> !$isunknown(rec_i));

endmodule

// ==== src/dside_cosim_top.sv ====
// data-side checking top: memory, access tracker and shadow checker
// the agent drives the bus ports, the external writer uses the backdoor
`timescale 1ns/1ps

module dside_cosim_top import dside_pkg::*; (
  input  logic             clk_i,
  input  logic             rst_ni,

  // data bus from the load/store agent
  input  logic             dmem_req_i,
  input  dmem_req_t        dmem_req_data_i,
  input  lsu_info_t        lsu_info_i,
  input  logic             mem_stall_i,
  output logic             dmem_gnt_o,
  output dmem_rsp_t        dmem_rsp_o,

  // external writer, not seen by the model
  input  logic             bd_valid_i,
  input  bd_wr_t           bd_wr_i,

  // checking results
  output logic             rec_valid_o,
  output access_rec_t      rec_o,
  output logic             mismatch_o,
  output logic [CNT_W-1:0] access_count_o,
  output logic [CNT_W-1:0] mismatch_count_o
);

  // --------------------------------------------------------------------------
  // memory
  // --------------------------------------------------------------------------

  data_mem u_data_mem (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .req_i      (dmem_req_i),
    .req_data_i (dmem_req_data_i),
    .stall_i    (mem_stall_i),
    .gnt_o      (dmem_gnt_o),
    .rsp_o      (dmem_rsp_o),
    .bd_valid_i (bd_valid_i),
    .bd_wr_i    (bd_wr_i)
  );

  // --------------------------------------------------------------------------
  // checking side
  // --------------------------------------------------------------------------

  dside_tracker u_tracker (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_i       (dmem_req_i),
    .gnt_i       (dmem_gnt_o),
    .req_data_i  (dmem_req_data_i),
    .lsu_info_i  (lsu_info_i),
    .rsp_i       (dmem_rsp_o),
    .rec_valid_o (rec_valid_o),
    .rec_o       (rec_o)
  );

  shadow_checker u_shadow_checker (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .rec_valid_i      (rec_valid_o),
    .rec_i            (rec_o),
    .mismatch_o       (mismatch_o),
    .access_count_o   (access_count_o),
    .mismatch_count_o (mismatch_count_o)
  );

endmodule

// ==== verif/dside_scoreboard.sv ====
// testbench checker: models memory, shadow and counters from the bus traffic
// compares every response, record, mismatch pulse and counter against the DUT ports
`timescale 1ns/1ps

module dside_scoreboard import dside_pkg::*; (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             dmem_req_i,
  input  dmem_req_t        dmem_req_data_i,
  input  lsu_info_t        lsu_info_i,
  input  logic             mem_stall_i,
  input  logic             exp_mismatch_i,
  input  logic             bd_valid_i,
  input  bd_wr_t           bd_wr_i,
  input  logic             dmem_gnt_i,
  input  dmem_rsp_t        dmem_rsp_i,
  input  logic             rec_valid_i,
  input  access_rec_t      rec_i,
  input  logic             mismatch_i,
  input  logic [CNT_W-1:0] access_count_i,
  input  logic [CNT_W-1:0] mismatch_count_i,
  output int               check_count_o,
  output int               error_count_o
);

  logic [31:0] mem_m    [MEM_WORDS];
  logic [31:0] shadow_m [MEM_WORDS];
  logic [3:0]  known_m  [MEM_WORDS];
  access_rec_t exp_rec;
  logic        pending;
  logic        tab_mm;
  logic        exp_mm;
  int          acc_cnt;
  int          mm_cnt;
  int          n_checks = 0;
  int          n_errors = 0;

  assign check_count_o = n_checks;
  assign error_count_o = n_errors;

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("error at %0t ns: %s expected %h got %h", $time, name, exp, got);
    end
  endtask

  // --------------------------------------------------------------------------
  // compare pre-edge values, then advance the model
  // --------------------------------------------------------------------------

  always @(posedge clk_i) begin
    logic                  xfer;
    logic                  oor;
    logic                  bus_wr;
    logic                  mm;
    logic [ADDR_IDX_W-1:0] idx;
    logic [31:0]           rdata;
    if (!rst_ni) begin
      pending = 1'b0;
      exp_mm  = 1'b0;
      acc_cnt = 0;
      mm_cnt  = 0;
      for (int w = 0; w < MEM_WORDS; w++) known_m[w] = 4'h0;
    end else begin
      compare("dmem_gnt_o", 32'(dmem_gnt_i), 32'(dmem_req_i & ~mem_stall_i));
      compare("dmem_rsp_o.rvalid", 32'(dmem_rsp_i.rvalid), 32'(pending));
      compare("rec_valid_o", 32'(rec_valid_i), 32'(pending));
      if (pending) begin
        compare("rec_o.store", 32'(rec_i.store), 32'(exp_rec.store));
        compare("rec_o.addr", rec_i.addr, exp_rec.addr);
        compare("rec_o.be", 32'(rec_i.be), 32'(exp_rec.be));
        compare("rec_o.data", rec_i.data, exp_rec.data);
        compare("rec_o.err", 32'(rec_i.err), 32'(exp_rec.err));
        compare("rec_o.misaligned_first", 32'(rec_i.misaligned_first),
                32'(exp_rec.misaligned_first));
        compare("rec_o.misaligned_second", 32'(rec_i.misaligned_second),
                32'(exp_rec.misaligned_second));
        compare("dmem_rsp_o.err", 32'(dmem_rsp_i.err), 32'(exp_rec.err));
        if (!exp_rec.store || exp_rec.err) begin
          compare("dmem_rsp_o.rdata", dmem_rsp_i.rdata, exp_rec.err ? 32'h0 : exp_rec.data);
        end
      end
      compare("mismatch_o", 32'(mismatch_i), 32'(exp_mm));
      compare("access_count_o", 32'(access_count_i), acc_cnt);
      compare("mismatch_count_o", 32'(mismatch_count_i), mm_cnt);

      // shadow side, one edge after the record
      exp_mm = 1'b0;
      if (pending) begin
        if (acc_cnt < (1 << CNT_W) - 1) acc_cnt++;
        idx = exp_rec.addr[ADDR_IDX_W+1:2];
        mm  = 1'b0;
        if (!exp_rec.err && exp_rec.store) begin
          for (int b = 0; b < 4; b++) begin
            if (exp_rec.be[b]) shadow_m[idx][8*b +: 8] = exp_rec.data[8*b +: 8];
          end
          known_m[idx] = known_m[idx] | exp_rec.be;
        end else if (!exp_rec.err) begin
          for (int b = 0; b < 4; b++) begin
            if (exp_rec.be[b] && known_m[idx][b] &&
                (shadow_m[idx][8*b +: 8] != exp_rec.data[8*b +: 8])) mm = 1'b1;
          end
        end
        exp_mm = mm;
        if (mm && (mm_cnt < (1 << CNT_W) - 1)) mm_cnt++;
        if (mm !== tab_mm) begin
          n_errors++;
          $display("table row for address %h expects mismatch %0b but the model predicts %0b",
                   exp_rec.addr, tab_mm, mm);
        end
      end

      // memory side, read before any write of this edge
      xfer    = dmem_req_i & ~mem_stall_i;
      pending = xfer;
      bus_wr  = 1'b0;
      idx     = dmem_req_data_i.addr[ADDR_IDX_W+1:2];
      if (xfer) begin
        oor   = dmem_req_data_i.addr[31:2] >= 30'(MEM_WORDS);
        rdata = (oor || dmem_req_data_i.we) ? 32'h0 : mem_m[idx];
        exp_rec.store             = dmem_req_data_i.we;
        exp_rec.addr              = dmem_req_data_i.addr;
        exp_rec.be                = dmem_req_data_i.be;
        exp_rec.data              = dmem_req_data_i.we ? dmem_req_data_i.wdata : rdata;
        exp_rec.err               = oor;
        exp_rec.misaligned_first  = lsu_info_i.misaligned_first;
        exp_rec.misaligned_second = lsu_info_i.misaligned_second;
        tab_mm = exp_mismatch_i;
        bus_wr = dmem_req_data_i.we & ~oor;
      end
      if (bd_valid_i && !(bus_wr && (idx == bd_wr_i.idx))) mem_m[bd_wr_i.idx] = bd_wr_i.data;
      if (bus_wr) begin
        for (int b = 0; b < 4; b++) begin
          if (dmem_req_data_i.be[b]) mem_m[idx][8*b +: 8] = dmem_req_data_i.wdata[8*b +: 8];
        end
      end
    end
  end

endmodule

// ==== verif/tb_dside_cosim.sv ====
// testbench for the data-side checking top
// applies a table of bus accesses and backdoor writes, the scoreboard does the checking
`timescale 1ns/1ps

module tb_dside_cosim import dside_pkg::*; ();

  localparam int TIMEOUT = 64;

  typedef struct packed {
    logic        bd;
    logic        we;
    logic [31:0] addr;
    logic [3:0]  be;
    logic [31:0] wdata;
    logic        mf;
    logic        ms;
    int          stall;
    logic        chain;
    logic        exp_mm;
  } row_t;

  logic             clk_i = 1'b0;
  logic             rst_ni;
  logic             dmem_req_i;
  dmem_req_t        dmem_req_data_i;
  lsu_info_t        lsu_info_i;
  logic             mem_stall_i;
  logic             dmem_gnt_o;
  dmem_rsp_t        dmem_rsp_o;
  logic             bd_valid_i;
  bd_wr_t           bd_wr_i;
  logic             rec_valid_o;
  access_rec_t      rec_o;
  logic             mismatch_o;
  logic [CNT_W-1:0] access_count_o;
  logic [CNT_W-1:0] mismatch_count_o;
  logic             exp_mm;
  int               sb_checks;
  int               sb_errors;
  row_t             rows [$];

  always #4 clk_i = ~clk_i;

  dside_cosim_top dut_i (.*);

  dside_scoreboard u_scoreboard (
    .exp_mismatch_i (exp_mm),
    .dmem_gnt_i     (dmem_gnt_o),
    .dmem_rsp_i     (dmem_rsp_o),
    .rec_valid_i    (rec_valid_o),
    .rec_i          (rec_o),
    .mismatch_i     (mismatch_o),
    .access_count_i (access_count_o),
    .mismatch_count_i (mismatch_count_o),
    .check_count_o  (sb_checks),
    .error_count_o  (sb_errors),
    .*
  );

  function automatic row_t acc(input logic we, input logic [31:0] addr, input logic [3:0] be,
                               input logic [31:0] wdata, input logic [1:0] lsu, input int stall,
                               input logic chain, input logic mm);
    row_t r = '0;
    r.we     = we;
    r.addr   = addr;
    r.be     = be;
    r.wdata  = wdata;
    r.mf     = lsu[1];
    r.ms     = lsu[0];
    r.stall  = stall;
    r.chain  = chain;
    r.exp_mm = mm;
    return r;
  endfunction

  function automatic row_t bdw(input logic [31:0] addr, input logic [31:0] wdata);
    row_t r = '0;
    r.bd    = 1'b1;
    r.addr  = addr;
    r.wdata = wdata;
    return r;
  endfunction

  // --------------------------------------------------------------------------
  // stimulus table
  // --------------------------------------------------------------------------

  task automatic build_table();
    // backdoor fill of words 0..31 so no load returns unknown data
    for (int i = 0; i < 32; i++) rows.push_back(bdw(32'(i * 4), $urandom));
    // merged byte-enabled stores, misaligned halves
    rows.push_back(acc(1'b1, 32'h10, 4'hf, 32'h11223344, 2'b00, 0, 1'b0, 1'b0));
    rows.push_back(acc(1'b1, 32'h10, 4'h6, 32'haabbccdd, 2'b00, 0, 1'b0, 1'b0));
    rows.push_back(acc(1'b0, 32'h10, 4'hf, 32'h0, 2'b00, 0, 1'b0, 1'b0));
    rows.push_back(acc(1'b1, 32'h16, 4'hc, 32'hbeef0000, 2'b10, 0, 1'b0, 1'b0));
    rows.push_back(acc(1'b1, 32'h18, 4'h1, 32'h000000aa, 2'b01, 0, 1'b0, 1'b0));
    rows.push_back(acc(1'b0, 32'h14, 4'hf, 32'h0, 2'b00, 0, 1'b0, 1'b0));
    rows.push_back(acc(1'b0, 32'h16, 4'hc, 32'h0, 2'b10, 0, 1'b0, 1'b0));
    // out of range, 0x410 aliases word 4 in the low index bits
    rows.push_back(acc(1'b1, 32'h410, 4'hf, 32'hdeadbeef, 2'b00, 0, 1'b0, 1'b0));
    rows.push_back(acc(1'b0, 32'h410, 4'hf, 32'h0, 2'b00, 0, 1'b0, 1'b0));
    rows.push_back(acc(1'b1, 32'hfffffffc, 4'h3, 32'h12345678, 2'b00, 0, 1'b0, 1'b0));
    rows.push_back(acc(1'b0, 32'h10, 4'hf, 32'h0, 2'b00, 0, 1'b0, 1'b0));
    // stalls with held requests and back-to-back grants
    rows.push_back(acc(1'b0, 32'h10, 4'hf, 32'h0, 2'b00, 5, 1'b1, 1'b0));
    rows.push_back(acc(1'b1, 32'h1c, 4'hf, 32'h55667788, 2'b00, 0, 1'b1, 1'b0));
    rows.push_back(acc(1'b0, 32'h1c, 4'hf, 32'h0, 2'b00, 3, 1'b1, 1'b0));
    rows.push_back(acc(1'b0, 32'h18, 4'h1, 32'h0, 2'b01, 0, 1'b0, 1'b0));
    // divergence through the backdoor
    rows.push_back(bdw(32'h10, 32'hcafef00d));
    rows.push_back(acc(1'b0, 32'h10, 4'hf, 32'h0, 2'b00, 0, 1'b0, 1'b1));
    rows.push_back(bdw(32'h14, 32'h12345678));
    rows.push_back(acc(1'b0, 32'h14, 4'h3, 32'h0, 2'b00, 0, 1'b0, 1'b0));
    rows.push_back(acc(1'b0, 32'h14, 4'hc, 32'h0, 2'b00, 0, 1'b0, 1'b1));
    rows.push_back(bdw(32'h24, 32'h0badf00d));
    rows.push_back(acc(1'b0, 32'h24, 4'hf, 32'h0, 2'b00, 0, 1'b0, 1'b0));
    // random traffic on words 16..31, never diverged
    for (int i = 0; i < 12; i++) begin
      rows.push_back(acc(1'($urandom_range(0, 1)), 32'($urandom_range(16, 31) << 2),
                         4'($urandom_range(1, 15)), $urandom, 2'b00,
                         int'($urandom_range(0, 3)), 1'($urandom_range(0, 1)), 1'b0));
    end
  endtask

  task automatic write_backdoor(input row_t r);
    bd_valid_i  = 1'b1;
    bd_wr_i.idx = r.addr[ADDR_IDX_W+1:2];
    bd_wr_i.data = r.wdata;
    @(negedge clk_i);
    bd_valid_i = 1'b0;
  endtask

  // returns at the falling edge after the transfer
  task automatic issue_access(input row_t r, output bit ok);
    int n = 0;
    bit granted = 1'b0;
    dmem_req_i      = 1'b1;
    dmem_req_data_i = '{we: r.we, addr: r.addr, be: r.be, wdata: r.wdata};
    lsu_info_i      = '{misaligned_first: r.mf, misaligned_second: r.ms};
    exp_mm          = r.exp_mm;
    mem_stall_i     = (r.stall != 0);
    while (!granted && n < TIMEOUT) begin
      @(posedge clk_i);
      granted = dmem_gnt_o;
      n++;
      @(negedge clk_i);
      if (n >= r.stall) mem_stall_i = 1'b0;
    end
    ok = granted;
    if (!granted) $display("timeout: request to %h not granted in %0d cycles", r.addr, TIMEOUT);
  endtask

  task automatic wait_record(output bit ok);
    int n = 0;
    ok = 1'b0;
    while (n < TIMEOUT) begin
      if (rec_valid_o) begin
        ok = 1'b1;
        break;
      end
      @(negedge clk_i);
      n++;
    end
    if (!ok) $display("timeout: no access record within %0d cycles", TIMEOUT);
  endtask

  // --------------------------------------------------------------------------
  // main sequence
  // --------------------------------------------------------------------------

  initial begin
    bit ok;
    bit failed = 1'b0;
    bit back_to_back;
    int n_tests = 0;
    void'($urandom(19084));
    rst_ni          = 1'b0;
    dmem_req_i      = 1'b0;
    dmem_req_data_i = '0;
    lsu_info_i      = '0;
    mem_stall_i     = 1'b0;
    bd_valid_i      = 1'b0;
    bd_wr_i         = '0;
    exp_mm          = 1'b0;
    build_table();
    repeat (16) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);

    for (int i = 0; i < rows.size(); i++) begin
      if (rows[i].bd) begin
        write_backdoor(rows[i]);
      end else begin
        issue_access(rows[i], ok);
        if (!ok) begin
          failed = 1'b1;
          break;
        end
        // next access goes out on this same falling edge
        back_to_back = rows[i].chain && (i + 1 < rows.size()) && !rows[i + 1].bd;
        if (!back_to_back) begin
          dmem_req_i = 1'b0;
          exp_mm     = 1'b0;
          wait_record(ok);
          if (!ok) begin
            failed = 1'b1;
            break;
          end
        end
      end
      n_tests++;
      $display("test %0d %s at %h done, errors so far %0d", i,
               rows[i].bd ? "backdoor" : (rows[i].we ? "store" : "load"), rows[i].addr, sb_errors);
    end

    // mismatch and counters settle two edges after the last transfer
    repeat (3) @(negedge clk_i);
    $display("tests %0d, checks %0d, errors %0d", n_tests, sb_checks, sb_errors);
    if (!failed && sb_errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// ==== sim.f ====
common/dside_pkg.sv
src/data_mem.sv
cosim/dside_tracker.sv
cosim/shadow_checker.sv
src/dside_cosim_top.sv
verif/dside_scoreboard.sv
verif/tb_dside_cosim.sv

// ==== run.sh ====
#!/bin/sh
# build with Verilator from sim.f and run, pass only if the pass line is printed
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module tb_dside_cosim -o tb_dside_cosim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/tb_dside_cosim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx '>>> PASS'; then
  exit 0
fi
exit 1
